/* all.f */
logic/opsum_pkg.sv
logic/glb_pkg.sv
logic/opsum_fifo.sv
logic/opsum_fifo_ctrl.sv
logic/glb_write_arbiter.sv
logic/glb_bank.sv
logic/opsum_writeback_top.sv
bench/opsum_writeback_assert.sv
bench/opsum_writeback_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module opsum_writeback_tb -f all.f -o opsum_writeback_sim \
    && ./obj_dir/opsum_writeback_sim +verilator+error+limit+100 | tee sim.log \
    || echo "build or simulation returned an error"

grep -q "^ALL CHECKS PASSED$" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1

/* bench/opsum_writeback_tb.sv */
module opsum_writeback_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import opsum_pkg::*;
    import glb_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_JOBS   = 7;

    // one row of the job table
    typedef struct packed {
        glb_addr_t   base;
        opsum_cnt_t  count;
        logic        clear;     // pulse the FIFO clear before start
        logic        loader;    // random loader traffic during the job
        logic [31:0] seed;      // psum data seed
    } job_t;

    // base, count, clear, loader, seed
    localparam job_t JOBS [NUM_JOBS] = '{
        '{12'h000, 8'd3,  1'b1, 1'b0, 32'h0000a5f7},
        '{12'h040, 8'd20, 1'b1, 1'b0, 32'h00003c91},    // several fill/drain rounds
        '{12'h040, 8'd6,  1'b0, 1'b0, 32'h000077e2},    // continues after the previous job
        '{12'h100, 8'd16, 1'b1, 1'b1, 32'h00005d0b},
        '{12'h180, 8'd16, 1'b1, 1'b0, 32'h00005d0b},    // same data, quiet loader
        '{12'h006, 8'd5,  1'b1, 1'b0, 32'h00001f4e},    // upper lane, lower one holds job 0 data
        '{12'h300, 8'd30, 1'b1, 1'b1, 32'h00009a66}
    };

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       fifo_clear;
    opsum_cnt_t push_num;
    glb_addr_t  base_addr;
    logic       need_push;
    opsum_t     psum_data;
    logic       psum_push;
    logic       loader_req;
    logic       loader_gnt;
    glb_addr_t  rd_addr;
    glb_data_t  rd_data;
    logic       done;

    glb_data_t   ref_mem [GLB_WORDS];
    glb_addr_t   exp_ptr     = '0;
    logic [31:0] loader_rng  = 32'ha5f7;
    logic        push_seen   = 1'b0;
    int          bank_writes = 0;
    int          err_cnt     = 0;
    int          check_cnt   = 0;

    opsum_writeback_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .fifo_clear_i  (fifo_clear),
        .push_num_i    (push_num),
        .base_addr_i   (base_addr),
        .need_push_i   (need_push),
        .psum_data_i   (psum_data),
        .psum_push_o   (psum_push),
        .loader_req_i  (loader_req),
        .loader_gnt_o  (loader_gnt),
        .glb_rd_addr_i (rd_addr),
        .glb_rd_data_o (rd_data),
        .done_o        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // accept strobe and bank writes as seen at the rising edge
    always @(posedge clk) begin
        push_seen <= psum_push;
        if (i_dut.bank_we) begin
            bank_writes <= bank_writes + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // grant follows the request by one registered cycle
    task automatic drive_loader(input logic enable);
        check_cnt++;
        assert (loader_gnt == loader_req) else begin
            $display("Error: t=%0t loader grant %b, request in the previous cycle %b",
                     $time, loader_gnt, loader_req);
            err_cnt++;
        end
        loader_rng = xorshift32(loader_rng);
        loader_req = enable && (loader_rng[1:0] == 2'b00);
    endtask

    // expected GLB contents, k-th psum lands at base + 2k
    task automatic record_psum(input glb_addr_t base, input opsum_t value);
        glb_addr_t addr;
        glb_idx_t  idx;
        addr = base + exp_ptr;
        idx  = addr[GLB_ADDR_W-1:2];
        if (addr[1]) begin
            ref_mem[idx][31:16] = value;    // upper half-word
        end else begin
            ref_mem[idx][15:0] = value;
        end
        exp_ptr = exp_ptr + glb_addr_t'(2);
    endtask

    task automatic read_word(input int w, output glb_data_t data);
        @(negedge clk);
        rd_addr = glb_addr_t'(w * 4);
        @(negedge clk);
        data = rd_data;    // registered read
    endtask

    task automatic check_idle_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_cnt++;
            assert (done && !psum_push && (bank_writes == 0)) else begin
                $display("Error: t=%0t after reset done=%b push=%b writes=%0d",
                         $time, done, psum_push, bank_writes);
                err_cnt++;
            end
        end
        $display("reset: done high and no GLB writes");
    endtask

    task automatic run_job(input int r);
        job_t        job;
        logic [31:0] data_rng;
        glb_addr_t   first_addr;
        glb_addr_t   last_addr;
        glb_data_t   got;
        int          sent;
        int          errs_before;
        int          writes_before;
        int          lo;
        int          hi;
        job         = JOBS[r];
        errs_before = err_cnt;
        data_rng    = job.seed;
        if (job.clear) begin
            @(negedge clk);
            fifo_clear = 1'b1;
            @(negedge clk);
            fifo_clear = 1'b0;
            exp_ptr = '0;    // pointer back to the base
        end
        writes_before = bank_writes;
        first_addr    = job.base + exp_ptr;
        @(negedge clk);
        base_addr = job.base;
        push_num  = job.count;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_cnt++;
        assert (!done) else begin
            $display("Error: t=%0t job %0d done still high after start", $time, r);
            err_cnt++;
        end
        // PE array model, next psum after each accept
        data_rng  = xorshift32(data_rng);
        psum_data = data_rng[15:0];
        need_push = 1'b1;
        sent      = 0;
        while (sent < int'(job.count)) begin
            @(negedge clk);
            drive_loader(job.loader);
            if (push_seen) begin
                record_psum(job.base, psum_data);
                sent++;
                if (sent < int'(job.count)) begin
                    data_rng  = xorshift32(data_rng);
                    psum_data = data_rng[15:0];
                end else begin
                    need_push = 1'b0;
                end
            end
        end
        while (!done) begin
            @(negedge clk);
            drive_loader(job.loader);
        end
        loader_req = 1'b0;
        check_cnt++;
        assert (bank_writes - writes_before == int'(job.count)) else begin
            $display("Error: t=%0t job %0d wrote %0d psums, expected %0d",
                     $time, r, bank_writes - writes_before, job.count);
            err_cnt++;
        end
        // touched words plus one neighbour on each side
        last_addr = job.base + exp_ptr - glb_addr_t'(2);
        lo = int'(first_addr[GLB_ADDR_W-1:2]) - 1;
        hi = int'(last_addr[GLB_ADDR_W-1:2]) + 1;
        if (lo < 0) begin
            lo = 0;
        end
        if (hi > GLB_WORDS - 1) begin
            hi = GLB_WORDS - 1;
        end
        for (int w = lo; w <= hi; w++) begin
            read_word(w, got);
            check_cnt++;
            assert (got == ref_mem[w]) else begin
                $display("Error: t=%0t job %0d word 0x%03h read 0x%08h expected 0x%08h",
                         $time, r, w, got, ref_mem[w]);
                err_cnt++;
            end
        end
        $display("job %0d: base 0x%03h, %0d psums, words %0d..%0d, %0d errors",
                 r, job.base, job.count, lo, hi, err_cnt - errs_before);
    endtask

    // same data with and without loader traffic must match word for word
    task automatic compare_loader_jobs(input int a, input int b);
        glb_data_t word_a;
        glb_data_t word_b;
        int        n_words;
        int        errs_before;
        errs_before = err_cnt;
        n_words     = (int'(JOBS[a].count) + 1) / 2;
        for (int k = 0; k < n_words; k++) begin
            read_word(int'(JOBS[a].base[GLB_ADDR_W-1:2]) + k, word_a);
            read_word(int'(JOBS[b].base[GLB_ADDR_W-1:2]) + k, word_b);
            check_cnt++;
            assert (word_a == word_b) else begin
                $display("Error: t=%0t word %0d differs, job %0d 0x%08h job %0d 0x%08h",
                         $time, k, a, word_a, b, word_b);
                err_cnt++;
            end
        end
        $display("loader compare: jobs %0d and %0d, %0d words, %0d errors",
                 a, b, n_words, err_cnt - errs_before);
    endtask

    initial begin
        int assert_fails;
        start      = 1'b0;
        fifo_clear = 1'b0;
        push_num   = '0;
        base_addr  = '0;
        need_push  = 1'b0;
        psum_data  = '0;
        loader_req = 1'b0;
        rd_addr    = '0;
        rst_n      = 1'b0;
        for (int w = 0; w < GLB_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle_after_reset();
        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(r);
        end
        compare_loader_jobs(3, 4);
        assert_fails = i_dut.i_arb.i_arb_chk.fail_cnt + i_dut.i_ctrl.i_ctrl_chk.fail_cnt;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 check_cnt, err_cnt, assert_fails);
        if ((err_cnt == 0) && (assert_fails == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, 40 cycles per psum plus slack for reset and readback
    initial begin
        int budget;
        budget = 500;
        for (int r = 0; r < NUM_JOBS; r++) begin
            budget += int'(JOBS[r].count) * 40;
        end
        repeat (budget) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", budget);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* bench/opsum_writeback_assert.sv */
module opsum_writeback_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 loader_req_i,
    input logic                 loader_gnt_i,
    input logic                 opsum_gnt_i,
    input logic                 busy_i,
    input logic                 bank_we_i,
    input logic                 clear_i,
    input logic                 wr_req_i,
    input logic                 fifo_pop_i,
    input logic                 psum_push_i,
    input opsum_pkg::wb_state_e state_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import opsum_pkg::*;

    int fail_cnt = 0;    // summed by the testbench
    int occ_q;           // FIFO fill rebuilt from the strobes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_q <= 0;
        end else if (clear_i) begin
            occ_q <= 0;
        end else begin
            occ_q <= occ_q + int'(psum_push_i) - int'(fifo_pop_i);
        end
    end

    // a loader request wins the next cycle alone
    grants_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) loader_req_i |=> (loader_gnt_i && !opsum_gnt_i)
    ) else begin
        fail_cnt++;
        $error("loader request not followed by an exclusive loader grant");
    end

    // a bank write needs a free GLB and no loader request one cycle earlier
    no_write_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) bank_we_i |-> $past(!busy_i && !loader_req_i)
    ) else begin
        fail_cnt++;
        $error("bank write granted while the loader held or requested the GLB");
    end

    pop_needs_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
            fifo_pop_i |-> (opsum_gnt_i && $past(wr_req_i && (state_i == POP)))
    ) else begin
        fail_cnt++;
        $error("FIFO pop without a granted request from POP");
    end

    no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) psum_push_i |-> (occ_q < FIFO_DEPTH)
    ) else begin
        fail_cnt++;
        $error("psum accepted while the FIFO is full");
    end

endmodule

bind glb_write_arbiter opsum_writeback_assert i_arb_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .loader_req_i (loader_req_i),
    .loader_gnt_i (loader_gnt_o),
    .opsum_gnt_i  (opsum_gnt_o),
    .busy_i       (busy_o),
    .bank_we_i    (bank_we_o),
    .clear_i      (1'b0),
    .wr_req_i     (opsum_req_i),
    .fifo_pop_i   (1'b0),
    .psum_push_i  (1'b0),
    .state_i      (opsum_pkg::IDLE)
);

bind opsum_fifo_ctrl opsum_writeback_assert i_ctrl_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .loader_req_i (1'b0),
    .loader_gnt_i (1'b0),
    .opsum_gnt_i  (gnt_i),
    .busy_i       (busy_i),
    .bank_we_i    (1'b0),
    .clear_i      (clear_i),
    .wr_req_i     (wr_req_o),
    .fifo_pop_i   (fifo_pop_o),
    .psum_push_i  (psum_push_o),
    .state_i      (state_q)
);

/* logic/opsum_writeback_top.sv */
module opsum_writeback_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic                  fifo_clear_i,
    input  opsum_pkg::opsum_cnt_t push_num_i,
    input  glb_pkg::glb_addr_t    base_addr_i,
    input  logic                  need_push_i,
    input  opsum_pkg::opsum_t     psum_data_i,
    output logic                  psum_push_o,
    input  logic                  loader_req_i,
    output logic                  loader_gnt_o,
    input  glb_pkg::glb_addr_t    glb_rd_addr_i,
    output glb_pkg::glb_data_t    glb_rd_data_o,
    output logic                  done_o
);
    import opsum_pkg::*;
    import glb_pkg::*;

    opsum_t  fifo_head;
    logic    fifo_empty;
    logic    fifo_full;
    logic    fifo_pop;
    logic    wr_req;
    logic    opsum_gnt;
    logic    glb_busy;
    logic    bank_we;
    glb_wr_t opsum_wr;
    glb_wr_t bank_wr;

    opsum_fifo i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (fifo_clear_i),
        .push_i      (psum_push_o),    // accept strobe is the push
        .push_data_i (psum_data_i),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    opsum_fifo_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .clear_i      (fifo_clear_i),
        .push_num_i   (push_num_i),
        .base_addr_i  (base_addr_i),
        .need_push_i  (need_push_i),
        .busy_i       (glb_busy),
        .gnt_i        (opsum_gnt),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_head_i  (fifo_head),
        .psum_push_o  (psum_push_o),
        .fifo_pop_o   (fifo_pop),
        .wr_req_o     (wr_req),
        .wr_o         (opsum_wr),
        .done_o       (done_o)
    );

    glb_write_arbiter i_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .loader_req_i (loader_req_i),
        .opsum_req_i  (wr_req),
        .opsum_wr_i   (opsum_wr),
        .loader_gnt_o (loader_gnt_o),
        .opsum_gnt_o  (opsum_gnt),
        .busy_o       (glb_busy),
        .bank_we_o    (bank_we),
        .bank_wr_o    (bank_wr)
    );

    glb_bank i_bank (
        .clk       (clk),
        .we_i      (bank_we),
        .wr_i      (bank_wr),
        .rd_addr_i (glb_rd_addr_i),
        .rd_data_o (glb_rd_data_o)
    );

endmodule

/* logic/glb_bank.sv */
module glb_bank (
    input  logic               clk,
    input  logic               we_i,
    input  glb_pkg::glb_wr_t   wr_i,
    input  glb_pkg::glb_addr_t rd_addr_i,
    output glb_pkg::glb_data_t rd_data_o
);
    import glb_pkg::*;

    glb_data_t mem [GLB_WORDS];
    glb_idx_t  wr_idx;
    glb_idx_t  rd_idx;

    // word index, byte offset bits dropped
    assign wr_idx = wr_i.addr[GLB_ADDR_W-1:2];
    assign rd_idx = rd_addr_i[GLB_ADDR_W-1:2];

    // zero contents at start of simulation
    initial begin
        for (int w = 0; w < GLB_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    // byte masked write
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < GLB_BE_W; b++) begin
                if (wr_i.be[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_i.data[8*b +: 8];
                end
            end
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_idx];
    end

endmodule

/* logic/glb_write_arbiter.sv */
module glb_write_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             loader_req_i,
    input  logic             opsum_req_i,
    input  glb_pkg::glb_wr_t opsum_wr_i,
    output logic             loader_gnt_o,
    output logic             opsum_gnt_o,
    output logic             busy_o,
    output logic             bank_we_o,
    output glb_pkg::glb_wr_t bank_wr_o
);
    import glb_pkg::*;

    glb_owner_e owner_q;
    glb_owner_e owner_d;

    // loader first, opsum only from a free GLB
    always_comb begin
        if (loader_req_i) begin
            owner_d = OWN_LOADER;    // held as long as the request stays
        end else if ((owner_q == OWN_NONE) && opsum_req_i) begin
            owner_d = OWN_OPSUM;
        end else begin
            owner_d = OWN_NONE;      // opsum grant lasts a single cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    assign loader_gnt_o = (owner_q == OWN_LOADER);
    assign opsum_gnt_o  = (owner_q == OWN_OPSUM);
    assign busy_o       = (owner_q == OWN_LOADER);

    // only opsum grants reach the bank
    assign bank_we_o = opsum_gnt_o;
    assign bank_wr_o = opsum_wr_i;

endmodule

/* logic/opsum_fifo_ctrl.sv */
module opsum_fifo_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic                  clear_i,
    input  opsum_pkg::opsum_cnt_t push_num_i,
    input  glb_pkg::glb_addr_t    base_addr_i,
    input  logic                  need_push_i,
    input  logic                  busy_i,
    input  logic                  gnt_i,
    input  logic                  fifo_empty_i,
    input  logic                  fifo_full_i,
    input  opsum_pkg::opsum_t     fifo_head_i,
    output logic                  psum_push_o,
    output logic                  fifo_pop_o,
    output logic                  wr_req_o,
    output glb_pkg::glb_wr_t      wr_o,
    output logic                  done_o
);
    import opsum_pkg::*;
    import glb_pkg::*;

    wb_state_e  state_q;
    wb_state_e  state_d;
    opsum_cnt_t target_q;
    opsum_cnt_t push_cnt_q;
    opsum_cnt_t push_cnt_inc;
    burst_cnt_t gnt_cnt_q;
    glb_addr_t  wr_ptr_q;
    glb_addr_t  wr_addr;
    logic       all_pushed;
    logic       last_push;
    logic       burst_open;

    assign push_cnt_inc = push_cnt_q + 1'b1;
    assign all_pushed   = (push_cnt_q == target_q);
    assign burst_open   = (gnt_cnt_q < burst_cnt_t'(DRAIN_BURST));

    // accept strobe back to the PE array, doubles as FIFO push
    assign psum_push_o = (state_q == PUSH) && need_push_i && !fifo_full_i && !all_pushed;
    assign last_push   = psum_push_o && (push_cnt_inc == target_q);

    assign wr_req_o   = (state_q == POP) && !fifo_empty_i && burst_open;
    assign fifo_pop_o = (state_q == POP) && gnt_i && !fifo_empty_i;    // pop with the write

    assign done_o = (state_q == IDLE) && all_pushed;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = PUSH;
                end
            end
            PUSH: begin
                // fill until full or the job count is reached
                if (all_pushed || last_push || fifo_full_i) begin
                    state_d = POP;
                end
            end
            POP: begin
                if (fifo_empty_i) begin
                    state_d = all_pushed ? IDLE : PUSH;
                end else if (!burst_open) begin
                    state_d = PUSH;    // phase over, PUSH hands back if nothing to take
                end else if (busy_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (!busy_i) begin
                    state_d = POP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            target_q   <= '0;
            push_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == IDLE) && start_i) begin
                target_q   <= push_num_i;
                push_cnt_q <= '0;
            end else if (psum_push_o) begin
                push_cnt_q <= push_cnt_inc;
            end
        end
    end

    // grants in the current drain phase, kept across WAIT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_cnt_q <= '0;
        end else if ((state_q == IDLE) || (state_q == PUSH)) begin
            gnt_cnt_q <= '0;
        end else if (fifo_pop_o) begin
            gnt_cnt_q <= gnt_cnt_q + 1'b1;
        end
    end

    // byte offset from base, keeps counting across jobs until cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
        end else if (fifo_pop_o) begin
            wr_ptr_q <= wr_ptr_q + glb_addr_t'(LANE_W / 8);    // one half-word
        end
    end

    assign wr_addr = base_addr_i + wr_ptr_q;

    // half-word lane from address bit 1
    always_comb begin
        wr_o.addr = wr_addr;
        if (wr_addr[LANE_SEL_BIT]) begin
            wr_o.be   = BE_LANE_HI;
            wr_o.data = glb_data_t'(fifo_head_i) << LANE_W;
        end else begin
            wr_o.be   = BE_LANE_LO;
            wr_o.data = glb_data_t'(fifo_head_i);    // zero extended
        end
    end

endmodule

/* logic/opsum_fifo.sv */
module opsum_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear_i,
    input  logic              push_i,
    input  opsum_pkg::opsum_t push_data_i,
    input  logic              pop_i,
    output opsum_pkg::opsum_t head_o,
    output logic              empty_o,
    output logic              full_o
);
    import opsum_pkg::*;

    opsum_t    mem [FIFO_DEPTH];
    fifo_idx_t wr_idx_q;
    fifo_idx_t rd_idx_q;
    fifo_cnt_t count_q;
    logic      push_ok;
    logic      pop_ok;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == fifo_cnt_t'(FIFO_DEPTH));
    assign head_o  = mem[rd_idx_q];    // first word falls through

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_idx_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_idx_q <= wr_idx_q + 1'b1;    // wraps at depth
            end
            if (pop_ok) begin
                rd_idx_q <= rd_idx_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // none or both
            endcase
        end
    end

endmodule

/* logic/glb_pkg.sv */
package glb_pkg;

    localparam int GLB_ADDR_W   = 12;    // byte address
    localparam int GLB_DATA_W   = 32;
    localparam int GLB_BE_W     = GLB_DATA_W / 8;
    localparam int GLB_WORDS    = 1024;
    localparam int GLB_IDX_W    = GLB_ADDR_W - 2;    // word index, byte bits dropped

    // half-word lanes inside one GLB word
    localparam int LANE_W       = 16;
    localparam int LANE_SEL_BIT = 1;
    localparam logic [GLB_BE_W-1:0] BE_LANE_LO = 4'b0011;
    localparam logic [GLB_BE_W-1:0] BE_LANE_HI = 4'b1100;

    typedef logic [GLB_ADDR_W-1:0] glb_addr_t;
    typedef logic [GLB_IDX_W-1:0]  glb_idx_t;
    typedef logic [GLB_BE_W-1:0]   glb_be_t;
    typedef logic [GLB_DATA_W-1:0] glb_data_t;

    // one write token, data already lane aligned
    typedef struct packed {
        glb_addr_t addr;
        glb_be_t   be;
        glb_data_t data;
    } glb_wr_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_LOADER,
        OWN_OPSUM
    } glb_owner_e;

endpackage

/* logic/opsum_pkg.sv */
package opsum_pkg;

    // psum payload and job size
    localparam int OPSUM_W     = 16;
    localparam int OPSUM_CNT_W = 8;    // up to 255 psums per job

    // FIFO geometry, depth is a power of two
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_IDX_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_IDX_W + 1;    // holds 0..FIFO_DEPTH

    // grants allowed per drain phase
    localparam int DRAIN_BURST = FIFO_DEPTH;
    localparam int BURST_CNT_W = $clog2(DRAIN_BURST + 1);

    typedef logic [OPSUM_W-1:0]     opsum_t;
    typedef logic [OPSUM_CNT_W-1:0] opsum_cnt_t;
    typedef logic [FIFO_IDX_W-1:0]  fifo_idx_t;
    typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;
    typedef logic [BURST_CNT_W-1:0] burst_cnt_t;

    // writeback controller states
    typedef enum logic [1:0] {
        IDLE,
        PUSH,
        POP,
        WAIT
    } wb_state_e;

endpackage
